// File: Bender.yml
package:
  name: chdr_xbar

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/xbar_pkg.sv
      - hdl/route_table.sv
      - hdl/ingress_port.sv
      - hdl/egress_arbiter.sv
      - hdl/chdr_xbar_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/xbar_tb.sv

// File: hdl/chdr_xbar_top.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module chdr_xbar_top (
  input  logic                    clk,
  input  logic                    reset,
  // Input ports
  input  xbar_pkg::chdr_beat_t    i_in_beat [`XBAR_NPORTS],
  input  logic [`XBAR_NPORTS-1:0] i_in_valid,
  output logic [`XBAR_NPORTS-1:0] o_in_ready,
  // Output ports
  output xbar_pkg::chdr_beat_t    o_out_beat [`XBAR_NPORTS],
  output logic [`XBAR_NPORTS-1:0] o_out_valid,
  input  logic [`XBAR_NPORTS-1:0] i_out_ready,
  // Routing table configuration
  input  xbar_pkg::rtcfg_req_t    i_rtcfg,
  output logic                    o_rtcfg_ack
);

  // --------------------
  // Interconnect
  // --------------------

  // Lookup traffic between ingress ports and the table
  xbar_pkg::epid_t         lookup_epid [`XBAR_NPORTS];
  logic [`XBAR_NPORTS-1:0] lookup_hit;
  xbar_pkg::port_idx_t     lookup_port [`XBAR_NPORTS];

  // Tagged beats broadcast from every ingress port to every arbiter
  xbar_pkg::routed_beat_t  routed       [`XBAR_NPORTS];
  logic [`XBAR_NPORTS-1:0] routed_valid;

  // Ready vectors indexed by arbiter, then the same bits indexed by ingress
  logic [`XBAR_NPORTS-1:0] egr_ready [`XBAR_NPORTS];
  logic [`XBAR_NPORTS-1:0] ing_ready [`XBAR_NPORTS];

  // Shared by all inputs
  route_table u_route_table (
    .clk           (clk),
    .reset         (reset),
    .i_rtcfg       (i_rtcfg),
    .o_rtcfg_ack   (o_rtcfg_ack),
    .i_lookup_epid (lookup_epid),
    .o_lookup_hit  (lookup_hit),
    .o_lookup_port (lookup_port)
  );

  genvar n, m;

  for (n = 0; n < `XBAR_NPORTS; n++) begin : g_ingress
    ingress_port u_ingress (
      .clk           (clk),
      .reset         (reset),
      .i_beat        (i_in_beat[n]),
      .i_valid       (i_in_valid[n]),
      .o_ready       (o_in_ready[n]),
      .o_lookup_epid (lookup_epid[n]),
      .i_lookup_hit  (lookup_hit[n]),
      .i_lookup_port (lookup_port[n]),
      .o_routed      (routed[n]),
      .o_valid       (routed_valid[n]),
      .i_ready_vec   (ing_ready[n])
    );
  end

  // Ingress n hears bit n from each arbiter m
  for (n = 0; n < `XBAR_NPORTS; n++) begin : g_xpose_row
    for (m = 0; m < `XBAR_NPORTS; m++) begin : g_xpose_col
      assign ing_ready[n][m] = egr_ready[m][n];
    end
  end

  // The generate index tells each arbiter which output it serves
  for (m = 0; m < `XBAR_NPORTS; m++) begin : g_egress
    egress_arbiter #(
      .OUT_PORT (xbar_pkg::port_idx_t'(m))
    ) u_egress (
      .clk         (clk),
      .reset       (reset),
      .i_req_beat  (routed),
      .i_req_valid (routed_valid),
      .o_ready_vec (egr_ready[m]),
      .o_beat      (o_out_beat[m]),
      .o_valid     (o_out_valid[m]),
      .i_ready     (i_out_ready[m])
    );
  end

endmodule

// File: hdl/egress_arbiter.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module egress_arbiter #(
  parameter xbar_pkg::port_idx_t OUT_PORT = '0
) (
  input  logic                    clk,
  input  logic                    reset,
  // From all ingress ports
  input  xbar_pkg::routed_beat_t  i_req_beat [`XBAR_NPORTS],
  input  logic [`XBAR_NPORTS-1:0] i_req_valid,
  output logic [`XBAR_NPORTS-1:0] o_ready_vec,
  // Downstream sink
  output xbar_pkg::chdr_beat_t    o_beat,
  output logic                    o_valid,
  input  logic                    i_ready
);

  // Round-robin pick, starting just after the previous winner
  // Walking downwards lets the nearest requester overwrite the farther ones
  function automatic xbar_pkg::port_idx_t rr_pick(
    input logic [`XBAR_NPORTS-1:0] req,
    input xbar_pkg::port_idx_t     last
  );
    xbar_pkg::port_idx_t pick;
    int                  idx;
    pick = last;
    for (int i = `XBAR_NPORTS; i >= 1; i--) begin
      idx = (int'(last) + i) % `XBAR_NPORTS;
      if (req[idx]) begin
        pick = xbar_pkg::port_idx_t'(idx);
      end
    end
    return pick;
  endfunction

  // --------------------
  // Request decode
  // --------------------

  // Inputs holding a beat meant for this output
  logic [`XBAR_NPORTS-1:0] req;

  always_comb begin
    for (int n = 0; n < `XBAR_NPORTS; n++) begin
      req[n] = i_req_valid[n] && (i_req_beat[n].dest == OUT_PORT);
    end
  end

  // --------------------
  // Allocation
  // --------------------

  xbar_pkg::pkt_state_e pkt_state;

  // Winner of the last completed packet, seeds the next search
  xbar_pkg::port_idx_t last_grant;
  // Input that owns the output for the packet in flight
  xbar_pkg::port_idx_t pkt_grant;
  xbar_pkg::port_idx_t grant;

  logic out_xfer;

  // A fresh decision is only made at a packet boundary
  assign grant = (pkt_state == xbar_pkg::PKT_HEAD) ? rr_pick(req, last_grant) : pkt_grant;

  // The mux follows the grant with no added cycle
  assign o_beat   = i_req_beat[grant].beat;
  assign o_valid  = req[grant];
  assign out_xfer = o_valid && i_ready;

  // Ready goes back only to the owner, and only when the sink can take it
  always_comb begin
    for (int n = 0; n < `XBAR_NPORTS; n++) begin
      o_ready_vec[n] = (grant == xbar_pkg::port_idx_t'(n)) && req[n] && i_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_state  <= xbar_pkg::PKT_HEAD;
      // Highest port, so the first search after reset starts at port 0
      last_grant <= xbar_pkg::port_idx_t'(`XBAR_NPORTS - 1);
      pkt_grant  <= '0;
    end else if (out_xfer) begin
      if (pkt_state == xbar_pkg::PKT_HEAD) begin
        pkt_grant <= grant;
      end
      if (o_beat.last) begin
        // Release the output and remember who just finished
        pkt_state  <= xbar_pkg::PKT_HEAD;
        last_grant <= grant;
      end else begin
        pkt_state <= xbar_pkg::PKT_BODY;
      end
    end
  end

endmodule

// File: hdl/ingress_port.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module ingress_port (
  input  logic                    clk,
  input  logic                    reset,
  // Upstream source
  input  xbar_pkg::chdr_beat_t    i_beat,
  input  logic                    i_valid,
  output logic                    o_ready,
  // Routing table lookup
  output xbar_pkg::epid_t         o_lookup_epid,
  input  logic                    i_lookup_hit,
  input  xbar_pkg::port_idx_t     i_lookup_port,
  // Towards the egress arbiters
  output xbar_pkg::routed_beat_t  o_routed,
  output logic                    o_valid,
  input  logic [`XBAR_NPORTS-1:0] i_ready_vec
);

  // --------------------
  // Packet tracking
  // --------------------

  // Follows beats as they are accepted from the source
  xbar_pkg::pkt_state_e pkt_state;

  // Destination chosen on the head beat, reused for the rest of the packet
  xbar_pkg::port_idx_t dest_q;
  xbar_pkg::port_idx_t head_dest;
  xbar_pkg::port_idx_t cur_dest;

  // Handshakes on both sides of the register
  logic in_xfer;
  logic drain;

  // One-entry output register
  logic                   full_q;
  xbar_pkg::routed_beat_t routed_q;

  // The EPID only means something on a head beat
  // Body beats still drive a lookup but its result is ignored
  assign o_lookup_epid = i_beat.data[`XBAR_EPID_W-1:0];

  // Misses fall back to the default port
  assign head_dest = i_lookup_hit ? i_lookup_port
                                  : xbar_pkg::port_idx_t'(`XBAR_DEFAULT_PORT);

  assign cur_dest = (pkt_state == xbar_pkg::PKT_HEAD) ? head_dest : dest_q;

  // An arbiter sets at most one bit, and only for the output it granted us
  assign drain = full_q && (|i_ready_vec);

  // Accept when empty, or when the held beat is leaving this very cycle
  assign o_ready = !full_q || drain;
  assign in_xfer = i_valid && o_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_state <= xbar_pkg::PKT_HEAD;
    end else if (in_xfer) begin
      pkt_state <= i_beat.last ? xbar_pkg::PKT_HEAD : xbar_pkg::PKT_BODY;
    end
  end

  // Capture the route when the head beat goes in
  always_ff @(posedge clk) begin
    if (in_xfer && (pkt_state == xbar_pkg::PKT_HEAD)) begin
      dest_q <= head_dest;
    end
  end

  // --------------------
  // Output register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (in_xfer) begin
      // A new beat replaces a draining one, so the register stays full
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      routed_q.beat <= i_beat;
      routed_q.dest <= cur_dest;
    end
  end

  // Every arbiter sees this beat; only the addressed one picks it up
  assign o_routed = routed_q;
  assign o_valid  = full_q;

endmodule

// File: hdl/route_table.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module route_table (
  input  logic                  clk,
  input  logic                  reset,
  // Side-channel table writes
  input  xbar_pkg::rtcfg_req_t  i_rtcfg,
  output logic                  o_rtcfg_ack,
  // One lookup per ingress port
  input  xbar_pkg::epid_t       i_lookup_epid [`XBAR_NPORTS],
  output logic [`XBAR_NPORTS-1:0] o_lookup_hit,
  output xbar_pkg::port_idx_t   o_lookup_port [`XBAR_NPORTS]
);

  localparam int ENT_W = $clog2(`XBAR_RT_SIZE);

  typedef logic [ENT_W-1:0] ent_idx_t;

  // --------------------
  // Table storage
  // --------------------

  // Per-entry valid bits are the only part of an entry that reset touches
  logic [`XBAR_RT_SIZE-1:0] entry_valid;
  xbar_pkg::epid_t          entry_epid [`XBAR_RT_SIZE];
  xbar_pkg::port_idx_t      entry_port [`XBAR_RT_SIZE];

  // Next entry to be replaced when a new EPID arrives
  ent_idx_t wr_ptr;

  // Where the incoming EPID already lives, if anywhere
  logic     cfg_hit;
  ent_idx_t cfg_idx;

  // Search the table for the EPID being written
  // EPIDs are kept unique, so at most one entry can match
  always_comb begin
    cfg_hit = 1'b0;
    cfg_idx = '0;
    for (int e = 0; e < `XBAR_RT_SIZE; e++) begin
      if (!cfg_hit && entry_valid[e] && (entry_epid[e] == i_rtcfg.epid)) begin
        cfg_hit = 1'b1;
        cfg_idx = ent_idx_t'(e);
      end
    end
  end

  // Control side of a write: fill a new slot, move the pointer, acknowledge
  always_ff @(posedge clk) begin
    if (reset) begin
      entry_valid <= '0;
      wr_ptr      <= '0;
      o_rtcfg_ack <= 1'b0;
    end else begin
      // Ack always follows the strobe by one cycle, hit or miss
      o_rtcfg_ack <= i_rtcfg.stb;
      if (i_rtcfg.stb && !cfg_hit) begin
        entry_valid[wr_ptr] <= 1'b1;
        // Wrap around so the oldest mapping is the next one evicted
        wr_ptr <= (wr_ptr == ent_idx_t'(`XBAR_RT_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
      end
    end
  end

  // Entry contents
  always_ff @(posedge clk) begin
    if (i_rtcfg.stb) begin
      if (cfg_hit) begin
        // Known EPID, so only its port changes and nothing is evicted
        entry_port[cfg_idx] <= i_rtcfg.port;
      end else begin
        entry_epid[wr_ptr] <= i_rtcfg.epid;
        entry_port[wr_ptr] <= i_rtcfg.port;
      end
    end
  end

  // --------------------
  // Parallel lookup
  // --------------------

  // Every ingress port compares against every valid entry in the same cycle
  always_comb begin
    for (int p = 0; p < `XBAR_NPORTS; p++) begin
      o_lookup_hit[p]  = 1'b0;
      o_lookup_port[p] = '0;
      for (int e = 0; e < `XBAR_RT_SIZE; e++) begin
        if (entry_valid[e] && (entry_epid[e] == i_lookup_epid[p])) begin
          o_lookup_hit[p]  = 1'b1;
          o_lookup_port[p] = entry_port[e];
        end
      end
    end
  end

endmodule

// File: hdl/xbar_pkg.sv
`include "xbar_params.svh"

package xbar_pkg;

  // --------------------
  // Index and ID types
  // --------------------

  // Selects one crossbar port
  typedef logic [$clog2(`XBAR_NPORTS)-1:0] port_idx_t;

  // Destination endpoint ID as carried in the head beat
  typedef logic [`XBAR_EPID_W-1:0] epid_t;

  // --------------------
  // Stream beats
  // --------------------

  // One beat on an input or output port
  typedef struct packed {
    logic [`XBAR_DATA_W-1:0] data;
    logic                    last;
  } chdr_beat_t;

  // A beat tagged with the output it is headed for
  typedef struct packed {
    chdr_beat_t beat;
    port_idx_t  dest;
  } routed_beat_t;

  // Single-cycle write into the routing table
  typedef struct packed {
    logic      stb;
    epid_t     epid;
    port_idx_t port;
  } rtcfg_req_t;

  // Position within a packet
  typedef enum logic {
    PKT_HEAD = 1'b0,
    PKT_BODY = 1'b1
  } pkt_state_e;

endpackage

// File: include/xbar_params.svh
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// --------------------
// Crossbar geometry
// --------------------

// Number of crossbar ports, both input and output side
`define XBAR_NPORTS 4

// Width of one stream beat, not counting the last flag
`define XBAR_DATA_W 64

// --------------------
// Routing table
// --------------------

// Endpoint ID width, taken from the low bits of the head beat
`define XBAR_EPID_W 16

// Number of EPID-to-port entries, replaced oldest first
`define XBAR_RT_SIZE 8

// Output port for packets whose EPID is not in the table
`define XBAR_DEFAULT_PORT 0

`endif

// File: sim/xbar_tb.sv
`timescale 1ns/1ps
`include "xbar_params.svh"

module xbar_tb;

  localparam int NP         = `XBAR_NPORTS;
  localparam int WAIT_LIMIT = 2000;

  logic                  clk;
  logic                  reset;
  xbar_pkg::chdr_beat_t  i_in_beat [NP];
  logic [NP-1:0]         i_in_valid;
  logic [NP-1:0]         o_in_ready;
  xbar_pkg::chdr_beat_t  o_out_beat [NP];
  logic [NP-1:0]         o_out_valid;
  logic [NP-1:0]         i_out_ready;
  xbar_pkg::rtcfg_req_t  i_rtcfg;
  logic                  o_rtcfg_ack;

  // Routing table model that is written alongside the DUT
  logic                  ref_valid [`XBAR_RT_SIZE];
  logic [15:0]           ref_epid [`XBAR_RT_SIZE];
  int                    ref_port [`XBAR_RT_SIZE];
  int                    ref_ptr;

  // Expected beats with one queue per output and source pair
  xbar_pkg::chdr_beat_t  exp_q [NP * NP][$];
  int                    seq [NP];
  bit                    rand_ready;
  // Monitor state for packet framing on each output
  bit                    in_pkt [NP];
  int                    cur_src [NP];
  bit                    log_en;
  int                    grant_log [$];

  chdr_xbar_top UUT (
    .clk         (clk),
    .reset       (reset),
    .i_in_beat   (i_in_beat),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_rtcfg     (i_rtcfg),
    .o_rtcfg_ack (o_rtcfg_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Checking helpers
  // --------------------

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_equal(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Table model with in-place update for a known EPID and FIFO replacement otherwise
  task automatic model_write(input logic [15:0] epid, input int port);
    int hit_idx;
    hit_idx = -1;
    for (int e = 0; e < `XBAR_RT_SIZE; e++) begin
      if (ref_valid[e] && ref_epid[e] == epid) hit_idx = e;
    end
    if (hit_idx >= 0) begin
      ref_port[hit_idx] = port;
    end else begin
      ref_valid[ref_ptr] = 1'b1;
      ref_epid[ref_ptr]  = epid;
      ref_port[ref_ptr]  = port;
      ref_ptr = (ref_ptr + 1) % `XBAR_RT_SIZE;
    end
  endtask

  // Output port a head beat with this EPID should reach
  function automatic int expected_port(input logic [15:0] epid);
    int port;
    port = `XBAR_DEFAULT_PORT;
    for (int e = 0; e < `XBAR_RT_SIZE; e++) begin
      if (ref_valid[e] && ref_epid[e] == epid) port = ref_port[e];
    end
    return port;
  endfunction

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int i = 0; i < NP * NP; i++) total += exp_q[i].size();
    return total;
  endfunction

  // --------------------
  // Stimulus
  // --------------------

  // Ack must sit low while the strobe is up and pulse for exactly one cycle after
  task automatic write_route(input logic [15:0] epid, input int port);
    i_rtcfg.stb  = 1'b1;
    i_rtcfg.epid = epid;
    i_rtcfg.port = xbar_pkg::port_idx_t'(port);
    @(negedge clk);
    check_equal("o_rtcfg_ack", o_rtcfg_ack, 0);
    @(posedge clk);
    #1;
    i_rtcfg.stb = 1'b0;
    model_write(epid, port);
    @(negedge clk);
    check_equal("o_rtcfg_ack", o_rtcfg_ack, 1);
    @(negedge clk);
    check_equal("o_rtcfg_ack", o_rtcfg_ack, 0);
    @(posedge clk);
    #1;
  endtask

  // Data holds source, sequence and beat index above the EPID
  task automatic send_packet(input int src, input logic [15:0] epid, input int nbeats);
    xbar_pkg::chdr_beat_t beats [6];
    int                   dest;
    int                   wait_cnt;
    for (int b = 0; b < nbeats; b++) begin
      beats[b].data = {8'(src), 16'(seq[src]), 8'(b), 16'h0, epid};
      beats[b].last = (b == nbeats - 1);
    end
    seq[src]++;
    for (int b = 0; b < nbeats; b++) begin
      i_in_beat[src]  = beats[b];
      i_in_valid[src] = 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (!o_in_ready[src]) begin
        wait_cnt++;
        if (wait_cnt > WAIT_LIMIT) begin
          $display("timed out waiting for o_in_ready on input %0d", src);
          stop_on_error();
        end
        @(negedge clk);
      end
      // Head accepted on the coming edge, so the whole packet is now expected
      if (b == 0) begin
        dest = expected_port(epid);
        for (int k = 0; k < nbeats; k++) exp_q[dest * NP + src].push_back(beats[k]);
      end
      @(posedge clk);
      #1;
    end
    i_in_valid[src] = 1'b0;
  endtask

  task automatic run_source(input int src, input int npkts, input logic [15:0] epid,
                            input bit random_epid, input bit gaps);
    logic [15:0] pkt_epid;
    int          r;
    for (int k = 0; k < npkts; k++) begin
      // 0x0200 is never programmed and always misses
      r = $urandom_range(0, 9);
      pkt_epid = random_epid ? ((r == 9) ? 16'h0300 : 16'h0200 + 16'(r)) : epid;
      send_packet(src, pkt_epid, $urandom_range(1, 6));
      if (gaps) begin
        repeat ($urandom_range(0, 2)) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  task automatic wait_drain(input string what);
    int cnt;
    cnt = 0;
    while (pending_beats() != 0) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("timed out waiting for the outputs to drain after %s", what);
        stop_on_error();
      end
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Sink ready changes just after each edge
  initial begin
    i_out_ready = '1;
    forever begin
      @(posedge clk);
      #1;
      i_out_ready = rand_ready ? NP'($urandom) : '1;
    end
  end

  // --------------------
  // Output monitor
  // --------------------

  initial begin : monitor
    xbar_pkg::chdr_beat_t beat;
    int                   src;
    int                   q;
    forever begin
      @(negedge clk);
      for (int o = 0; o < NP; o++) begin
        if (o_out_valid[o] && i_out_ready[o]) begin
          beat = o_out_beat[o];
          src  = int'(beat.data[63:56]);
          if (in_pkt[o]) begin
            // A granted packet must finish before another input gets the output
            check_equal($sformatf("source on output %0d", o), src, cur_src[o]);
          end else begin
            in_pkt[o]  = 1'b1;
            cur_src[o] = src;
            if (log_en && o == 3) grant_log.push_back(src);
          end
          q = o * NP + src;
          if (src >= NP || exp_q[q].size() == 0) begin
            $display("unexpected beat %h on output %0d from input %0d", beat, o, src);
            stop_on_error();
          end
          check_equal($sformatf("o_out_beat[%0d]", o), beat, exp_q[q][0]);
          void'(exp_q[q].pop_front());
          if (beat.last) in_pkt[o] = 1'b0;
        end
      end
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    void'($urandom(30127));
    reset      = 1'b1;
    i_in_valid = '0;
    i_rtcfg    = '0;
    rand_ready = 1'b0;
    log_en     = 1'b0;
    ref_ptr    = 0;
    for (int n = 0; n < NP; n++) begin
      i_in_beat[n] = '0;
      seq[n]       = 0;
      in_pkt[n]    = 1'b0;
    end
    for (int e = 0; e < `XBAR_RT_SIZE; e++) ref_valid[e] = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    check_equal("o_out_valid", o_out_valid, 0);
    check_equal("o_rtcfg_ack", o_rtcfg_ack, 0);
    // Empty ingress registers accept at once
    check_equal("o_in_ready", o_in_ready, {NP{1'b1}});

    // Empty table sends everything to the default port
    fork
      run_source(0, 3, 16'h0, 1'b1, 1'b0);
      run_source(1, 3, 16'h0, 1'b1, 1'b1);
      run_source(2, 3, 16'h0, 1'b1, 1'b0);
      run_source(3, 3, 16'h0, 1'b1, 1'b1);
    join
    wait_drain("the empty table test");

    // One programmed route
    write_route(16'h0101, 2);
    fork
      run_source(0, 2, 16'h0101, 1'b0, 1'b0);
      run_source(3, 2, 16'h0101, 1'b0, 1'b0);
    join
    wait_drain("the single route test");

    // Eight more EPIDs push 0x0101 out, then 0x0203 is moved in place
    // 0x0201 sits at the write pointer and must survive the in-place rewrite
    for (int k = 1; k <= 8; k++) write_route(16'h0200 + 16'(k), k % 3);
    write_route(16'h0203, 1);
    fork
      run_source(0, 2, 16'h0101, 1'b0, 1'b0);
      run_source(1, 2, 16'h0201, 1'b0, 1'b0);
      run_source(2, 4, 16'h0, 1'b1, 1'b1);
      run_source(3, 2, 16'h0203, 1'b0, 1'b0);
    join
    wait_drain("the replacement test");

    // All inputs compete for output 3, which has not granted anything yet
    write_route(16'h0300, 3);
    log_en = 1'b1;
    fork
      run_source(0, 3, 16'h0300, 1'b0, 1'b0);
      run_source(1, 3, 16'h0300, 1'b0, 1'b0);
      run_source(2, 3, 16'h0300, 1'b0, 1'b0);
      run_source(3, 3, 16'h0300, 1'b0, 1'b0);
    join
    wait_drain("the contention test");
    log_en = 1'b0;
    check_equal("grant count on output 3", grant_log.size(), 12);
    for (int i = 0; i < 12; i++) begin
      check_equal($sformatf("grant %0d on output 3", i), grant_log[i], i % NP);
    end

    // Random traffic with random back-pressure
    rand_ready = 1'b1;
    fork
      run_source(0, 20, 16'h0, 1'b1, 1'b1);
      run_source(1, 20, 16'h0, 1'b1, 1'b1);
      run_source(2, 20, 16'h0, 1'b1, 1'b1);
      run_source(3, 20, 16'h0, 1'b1, 1'b1);
    join
    wait_drain("the random traffic test");
    rand_ready = 1'b0;

    // Nothing may be left behind or duplicated inside the crossbar
    check_equal("o_out_valid", o_out_valid, 0);
    check_equal("o_in_ready", o_in_ready, {NP{1'b1}});

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
hdl/xbar_pkg.sv
hdl/route_table.sv
hdl/ingress_port.sv
hdl/egress_arbiter.sv
hdl/chdr_xbar_top.sv
sim/xbar_tb.sv
